// File: rtl/bp_pkg.sv
package bp_pkg;

    localparam int k_angle_width = 8;
    localparam int k_angle_45 = 45;
    localparam int k_angle_90 = 90;
    localparam int k_angle_135 = 135;

    localparam int k_data_width = 12;
    localparam int k_s_width = 7;
    localparam int k_slots = 8;
    localparam int k_partitions = 4;
    localparam int k_shift_steps = 8;
    localparam int k_s_base = 32;
    localparam int k_step_frac = 4;

    // Q1.4, spans 0.0 to 1.0
    typedef logic [4:0] step_t;

    typedef struct packed {
        step_t map_step;
        step_t shift_step;
    } angle_step_s;

    // tap 0 sits in the low bits
    typedef logic signed [k_partitions-1:0][k_data_width-1:0] taps_t;

    typedef struct packed {
        logic kick;
        logic scan_mode;
        logic scan_direction;
        taps_t taps;
    } pe_out_s;

    typedef struct packed {
        logic [k_angle_width-1:0] angle;
        logic valid;
    } fr_angle_s;

    // line memory region uses sample_w, register region uses ctrl_w
    typedef union packed {
        struct packed {
            logic [31-k_data_width:0] pad;
            logic signed [k_data_width-1:0] sample;
        } sample_w;
        struct packed {
            logic [18:0] pad;
            logic [k_angle_width-1:0] angle;
            logic [3:0] count;
            logic start;
        } ctrl_w;
    } wb_word_u;

    // folded to the first quadrant so both steps are plain magnitudes
    function automatic angle_step_s angle_step_f(input int angle);
        real rad;
        real scale;
        angle_step_s step;
        scale = real'(1 << k_step_frac);
        rad = ((angle > k_angle_90) ? (2 * k_angle_90 - angle) : angle) * 3.141592653589793 / 180.0;
        step.map_step = step_t'($rtoi(scale * $cos(rad) + 0.5));
        step.shift_step = step_t'($rtoi(scale * $sin(rad) + 0.5));
        return step;
    endfunction

endpackage

// File: rtl/bp_angle_lut.sv
`timescale 1ns/1ns

module bp_angle_lut
(
    input  logic clk,
    input  logic [bp_pkg::k_angle_width-1:0] angle,
    output bp_pkg::angle_step_s step
);

    import bp_pkg::*;

    // one entry per whole degree, 0 to 179
    angle_step_s lut [0:k_angle_135+k_angle_45-1];

    for (genvar a = 0; a < k_angle_135 + k_angle_45; a++)
    begin : g_entry
        assign lut[a] = angle_step_f(a);
    end

    // out of range angles hold the last step
    always_ff @(posedge clk)
    begin
        if (angle < k_angle_135 + k_angle_45)
            step <= lut[angle];
    end

endmodule

// File: rtl/bp_swappable.sv
`timescale 1ns/1ns

module bp_swappable
(
    input  logic clk,
    input  logic reset_n,
    input  bp_pkg::angle_step_s step,
    input  logic fill_kick,
    input  logic shift_kick,
    input  logic signed [bp_pkg::k_data_width-1:0] fr_val,
    output logic [bp_pkg::k_s_width-1:0] fr_s,
    output logic fill_done,
    output logic shift_done,
    output logic pe_kick,
    output bp_pkg::taps_t pe_taps
);

    import bp_pkg::*;

    angle_step_s step_q;
    logic [k_s_width+k_step_frac-1:0] accu;
    logic [k_s_width-1:0] last_s;
    logic [$clog2(k_partitions)-1:0] fill_cnt;
    logic [$clog2(k_partitions)-1:0] wr_idx;
    logic [$clog2(k_shift_steps)-1:0] shift_cnt;
    logic fill_active;
    logic fill_wr;
    logic shift_active;
    logic shift_phase;

    // fill starts at the fixed base, shift walks on from the tap 3 index
    assign fr_s = (shift_active ? last_s : k_s_width'(k_s_base))
                  + k_s_width'(accu >> k_step_frac);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_active <= 1'b0;
            fill_wr <= 1'b0;
            fill_done <= 1'b0;
            fill_cnt <= '0;
            shift_active <= 1'b0;
            shift_phase <= 1'b0;
            shift_done <= 1'b0;
            shift_cnt <= '0;
            pe_kick <= 1'b0;
            accu <= '0;
        end
        else
        begin
            pe_kick <= 1'b0;
            fill_wr <= fill_active;

            if (fill_kick)
            begin
                fill_active <= 1'b1;
                fill_done <= 1'b0;
                fill_cnt <= '0;
                accu <= '0;
            end
            else if (fill_active)
            begin
                accu <= accu + step_q.map_step;
                fill_cnt <= fill_cnt + 1'b1;
                // last address issued, its data lands next cycle
                if (fill_cnt == k_partitions - 1)
                begin
                    fill_active <= 1'b0;
                    fill_done <= 1'b1;
                end
            end

            if (shift_kick)
            begin
                shift_active <= 1'b1;
                shift_phase <= 1'b0;
                shift_done <= 1'b0;
                shift_cnt <= '0;
                accu <= step_q.shift_step;
            end
            else if (shift_active)
            begin
                // address cycle, then data cycle
                shift_phase <= !shift_phase;
                if (shift_phase)
                begin
                    pe_kick <= 1'b1;
                    accu <= accu + step_q.shift_step;
                    shift_cnt <= shift_cnt + 1'b1;
                    if (shift_cnt == k_shift_steps - 1)
                    begin
                        shift_active <= 1'b0;
                        shift_done <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_kick)
            step_q <= step;
        wr_idx <= fill_cnt;
        if (fill_active && fill_cnt == k_partitions - 1)
            last_s <= fr_s;
        if (fill_wr)
            pe_taps[wr_idx] <= fr_val;
        else if (shift_active && shift_phase)
            pe_taps <= {fr_val, pe_taps[k_partitions-1:1]};
    end

    // ping-pong never fills and shifts one buffer at once
    a_kick_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(fill_kick && shift_kick));

endmodule

// File: rtl/bp_swap_control.sv
`timescale 1ns/1ns

module bp_swap_control
(
    input  logic clk,
    input  logic reset_n,
    input  bp_pkg::fr_angle_s fr0,
    input  bp_pkg::fr_angle_s fr1,
    input  logic fr_next_angle_ack,
    input  logic signed [bp_pkg::k_data_width-1:0] fr0_val,
    input  logic signed [bp_pkg::k_data_width-1:0] fr1_val,
    output logic fr_next_angle,
    output logic fr_done,
    output logic [bp_pkg::k_s_width-1:0] fr0_s,
    output logic [bp_pkg::k_s_width-1:0] fr1_s,
    output bp_pkg::pe_out_s pe
);

    import bp_pkg::*;

    typedef enum logic [2:0] {
        ready_s,
        setup_1_s,
        setup_2_s,
        fill_s,
        fas_setup_1_s,
        fas_setup_2_s,
        fill_and_shift_s,
        shift_s
    } state_t;

    state_t state;
    state_t next_state;
    logic sel;
    logic req_pending;
    logic fill_kick;
    logic shift_kick;
    logic fill_done;
    logic shift_done;
    angle_step_s step;

    logic [1:0] sw_fill_kick;
    logic [1:0] sw_shift_kick;
    logic [1:0] sw_fill_done;
    logic [1:0] sw_shift_done;
    logic [1:0] sw_pe_kick;
    logic [k_s_width-1:0] sw_fr_s [2];
    logic signed [k_data_width-1:0] sw_fr_val [2];
    taps_t sw_taps [2];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ready_s;
            sel <= 1'b0;
            req_pending <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (state == fas_setup_1_s)
                sel <= !sel;
            if (fr_next_angle)
                req_pending <= 1'b1;
            else if (fr_next_angle_ack)
                req_pending <= 1'b0;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (fr_next_angle_ack)
                    next_state = setup_1_s;
            setup_1_s:
                next_state = setup_2_s;
            setup_2_s:
                next_state = fill_s;
            fill_s:
                if (fr_next_angle_ack)
                    next_state = fas_setup_1_s;
            fas_setup_1_s:
                next_state = fas_setup_2_s;
            fas_setup_2_s:
                next_state = fr0.valid ? fill_and_shift_s : shift_s;
            fill_and_shift_s:
                if (fr_next_angle_ack)
                    next_state = fas_setup_1_s;
            shift_s:
                if (shift_done)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // kicks go out once select has settled
    assign fill_kick = (state == setup_2_s || state == fas_setup_2_s) && fr0.valid;
    assign shift_kick = (state == setup_2_s || state == fas_setup_2_s) && fr1.valid;

    always_comb
    begin
        fr_next_angle = 1'b0;
        if (!req_pending)
        begin
            if (state == fill_s)
                fr_next_angle = fill_done;
            else if (state == fill_and_shift_s)
                fr_next_angle = fill_done && shift_done;
        end
    end

    assign fr_done = (state == shift_s) && shift_done;

    // sel picks the filling buffer, the other one shifts
    always_comb
    begin
        sw_fill_kick = '0;
        sw_shift_kick = '0;
        sw_fill_kick[sel] = fill_kick;
        sw_shift_kick[!sel] = shift_kick;
        sw_fr_val[sel] = fr0_val;
        sw_fr_val[!sel] = fr1_val;
        fill_done = sw_fill_done[sel];
        shift_done = sw_shift_done[!sel];
        fr0_s = sw_fr_s[sel];
        fr1_s = sw_fr_s[!sel];
    end

    always_comb
    begin
        pe.kick = sw_pe_kick[!sel];
        pe.taps = sw_taps[!sel];
        // y scan between 45 and 135, reverse from 90 up
        pe.scan_mode = (fr1.angle >= k_angle_45) && (fr1.angle < k_angle_135);
        pe.scan_direction = (fr1.angle >= k_angle_90);
    end

    bp_angle_lut angle_lut_i
    (
        .clk(clk),
        .angle(fr0.angle),
        .step(step)
    );

    for (genvar i = 0; i < 2; i++)
    begin : g_sw
        bp_swappable swappable_i
        (
            .clk(clk),
            .reset_n(reset_n),
            .step(step),
            .fill_kick(sw_fill_kick[i]),
            .shift_kick(sw_shift_kick[i]),
            .fr_val(sw_fr_val[i]),
            .fr_s(sw_fr_s[i]),
            .fill_done(sw_fill_done[i]),
            .shift_done(sw_shift_done[i]),
            .pe_kick(sw_pe_kick[i]),
            .pe_taps(sw_taps[i])
        );
    end

    // RAM acks on the next cycle and no request repeats before that
    a_next_angle_acked: assert property (@(posedge clk) disable iff (!reset_n)
        fr_next_angle |=> fr_next_angle_ack && !fr_next_angle);

    // run ends only with no angle left to fill
    a_done_in_shift: assert property (@(posedge clk) disable iff (!reset_n)
        fr_done |-> !fr0.valid);

endmodule

// File: rtl/bp_filtered_ram.sv
`timescale 1ns/1ns

module bp_filtered_ram
(
    input  logic clk,
    input  logic reset_n,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  logic [10:0] wb_adr,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic wb_ack,
    input  logic fr_next_angle,
    input  logic fr_done,
    output bp_pkg::fr_angle_s fr0,
    output bp_pkg::fr_angle_s fr1,
    output logic fr_next_angle_ack,
    input  logic [bp_pkg::k_s_width-1:0] fr0_s,
    input  logic [bp_pkg::k_s_width-1:0] fr1_s,
    output logic signed [bp_pkg::k_data_width-1:0] fr0_val,
    output logic signed [bp_pkg::k_data_width-1:0] fr1_val
);

    import bp_pkg::*;

    logic signed [k_data_width-1:0] line_mem [0:k_slots*(1<<k_s_width)-1];
    logic [k_angle_width-1:0] angle_tab [k_slots];
    logic [3:0] count;
    logic [3:0] next_entry;
    logic [$clog2(k_slots)-1:0] fr0_slot;
    logic [$clog2(k_slots)-1:0] fr1_slot;
    logic busy;
    logic done;

    wb_word_u wr_word;
    wb_word_u rd_word;
    logic [3:0] reg_word;
    logic wb_req;
    logic wr_mem;
    logic wr_reg;
    logic start;

    assign wr_word = wb_dat_i;
    assign reg_word = wb_adr[3:0];
    assign wb_req = wb_cyc && wb_stb && !wb_ack;
    // bit 10 splits line memory from registers
    assign wr_mem = wb_req && wb_we && !wb_adr[10];
    assign wr_reg = wb_req && wb_we && wb_adr[10];
    assign start = wr_reg && reg_word == 4'd0 && wr_word.ctrl_w.start && !busy
                   && wr_word.ctrl_w.count != 4'd0;

    always_comb
    begin
        rd_word = '0;
        if (!wb_adr[10])
        begin
            rd_word.sample_w.sample = line_mem[wb_adr[9:0]];
            rd_word.sample_w.pad = {(32-k_data_width){rd_word.sample_w.sample[k_data_width-1]}};
        end
        else
        begin
            case (reg_word)
                4'd0:
                    rd_word.ctrl_w.count = count;
                4'(k_slots + 1):
                    rd_word = {30'd0, done, busy};
                default:
                    if (reg_word <= k_slots)
                        rd_word.ctrl_w.angle = angle_tab[3'(reg_word - 4'd1)];
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_mem)
            line_mem[wb_adr[9:0]] <= wr_word.sample_w.sample;
        if (wr_reg && reg_word != 4'd0 && reg_word <= k_slots)
            angle_tab[3'(reg_word - 4'd1)] <= wr_word.ctrl_w.angle;
        wb_dat_o <= rd_word;
        // slot n holds the line of table entry n
        fr0_val <= line_mem[{fr0_slot, fr0_s}];
        fr1_val <= line_mem[{fr1_slot, fr1_s}];
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wb_ack <= 1'b0;
            count <= '0;
            busy <= 1'b0;
            done <= 1'b0;
            fr0 <= '0;
            fr1 <= '0;
            fr0_slot <= '0;
            fr1_slot <= '0;
            next_entry <= '0;
            fr_next_angle_ack <= 1'b0;
        end
        else
        begin
            wb_ack <= wb_req;
            fr_next_angle_ack <= 1'b0;
            if (wr_reg && reg_word == 4'd0)
                count <= wr_word.ctrl_w.count;

            if (start)
            begin
                busy <= 1'b1;
                done <= 1'b0;
                fr0 <= '{angle: angle_tab[0], valid: 1'b1};
                fr1.valid <= 1'b0;
                fr0_slot <= '0;
                next_entry <= 4'd1;
                fr_next_angle_ack <= 1'b1;
            end
            else if (fr_next_angle)
            begin
                // current takes the filled angle, fill moves to the next entry
                fr_next_angle_ack <= 1'b1;
                fr1 <= fr0;
                fr1_slot <= fr0_slot;
                if (next_entry < count && next_entry < k_slots)
                begin
                    fr0 <= '{angle: angle_tab[next_entry[$clog2(k_slots)-1:0]], valid: 1'b1};
                    fr0_slot <= next_entry[$clog2(k_slots)-1:0];
                    next_entry <= next_entry + 4'd1;
                end
                else
                    fr0.valid <= 1'b0;
            end

            if (fr_done)
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // host keeps cyc and stb up until it sees ack
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        wb_ack |-> wb_cyc && wb_stb);

endmodule

// File: rtl/bp_processing_top.sv
`timescale 1ns/1ns

module bp_processing_top
(
    input  logic clk,
    input  logic reset_n,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  logic [10:0] wb_adr,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic wb_ack,
    output bp_pkg::pe_out_s pe
);

    import bp_pkg::*;

    fr_angle_s fr0;
    fr_angle_s fr1;
    logic fr_next_angle;
    logic fr_next_angle_ack;
    logic fr_done;
    logic [k_s_width-1:0] fr0_s;
    logic [k_s_width-1:0] fr1_s;
    logic signed [k_data_width-1:0] fr0_val;
    logic signed [k_data_width-1:0] fr1_val;

    bp_filtered_ram filtered_ram_i
    (
        .clk(clk),
        .reset_n(reset_n),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o),
        .wb_ack(wb_ack),
        .fr_next_angle(fr_next_angle),
        .fr_done(fr_done),
        .fr0(fr0),
        .fr1(fr1),
        .fr_next_angle_ack(fr_next_angle_ack),
        .fr0_s(fr0_s),
        .fr1_s(fr1_s),
        .fr0_val(fr0_val),
        .fr1_val(fr1_val)
    );

    bp_swap_control swap_control_i
    (
        .clk(clk),
        .reset_n(reset_n),
        .fr0(fr0),
        .fr1(fr1),
        .fr_next_angle_ack(fr_next_angle_ack),
        .fr0_val(fr0_val),
        .fr1_val(fr1_val),
        .fr_next_angle(fr_next_angle),
        .fr_done(fr_done),
        .fr0_s(fr0_s),
        .fr1_s(fr1_s),
        .pe(pe)
    );

endmodule

// File: verification/bp_processing_tb.sv
`timescale 1ns/1ns

module bp_processing_tb;

    import bp_pkg::*;

    typedef struct packed {
        logic [3:0] count;
        logic [0:7][7:0] angles;
        logic [7:0] kicks;
    } test_s;

    // angle count, table angles, expected number of pe kicks
    test_s tests [5] = '{
        '{4'd1, '{8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0}, 8'd8},
        '{4'd4, '{8'd30, 8'd60, 8'd100, 8'd150, 8'd0, 8'd0, 8'd0, 8'd0}, 8'd32},
        '{4'd8, '{8'd0, 8'd20, 8'd45, 8'd70, 8'd90, 8'd115, 8'd135, 8'd170}, 8'd64},
        '{4'd6, '{8'd44, 8'd45, 8'd89, 8'd90, 8'd134, 8'd135, 8'd0, 8'd0}, 8'd48},
        '{4'd3, '{8'd179, 8'd10, 8'd91, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0}, 8'd24}
    };

    logic clk;
    logic reset_n;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [10:0] wb_adr;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic wb_ack;
    pe_out_s pe;

    integer seed = 57249;
    logic signed [k_data_width-1:0] line_copy [k_slots][1 << k_s_width];
    pe_out_s kicks [$];
    pe_out_s expected [$];

    bp_processing_top bp_processing_top_i
    (
        .clk(clk),
        .reset_n(reset_n),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o),
        .wb_ack(wb_ack),
        .pe(pe)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = !clk;
    end

    // kick is a one cycle pulse, mid-cycle sample catches each once
    always @(negedge clk)
    begin
        if (pe.kick)
            kicks.push_back(pe);
    end

    initial
    begin
        int limit;
        limit = 0;
        for (int t = 0; t < $size(tests); t++)
            limit += 200 * tests[t].count + 2000;
        repeat (limit) @(posedge clk);
        $display("run timed out after %0d cycles without finishing", limit);
        $display("Test failed");
        $fatal(1);
    end

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expect_val);
        if (actual !== expect_val)
        begin
            $display("CHECK FAILED %s: actual %h expected %h", name, actual, expect_val);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // host holds cyc and stb through the ack cycle
    task automatic write_word(input logic [10:0] adr, input logic [31:0] data);
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b1;
        wb_adr = adr;
        wb_dat_i = data;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!wb_ack);
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic read_word(input logic [10:0] adr, output logic [31:0] data);
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b0;
        wb_adr = adr;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!wb_ack);
        data = wb_dat_o;
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // round(16 * |x|)
    function automatic int scaled_step(input real x);
        real r;
        r = (x < 0.0) ? -x : x;
        return $rtoi(r * (1 << k_step_frac) + 0.5);
    endfunction

    // only the index window that fill and shift can reach is loaded
    task automatic load_lines(input int count);
        logic signed [k_data_width-1:0] v;
        for (int slot = 0; slot < count; slot++)
        begin
            for (int idx = k_s_base; idx < k_s_base + 16; idx++)
            begin
                v = $random(seed);
                line_copy[slot][idx] = v;
                write_word({1'b0, 3'(slot), 7'(idx)}, {{(32 - k_data_width){1'b0}}, v});
            end
        end
    endtask

    task automatic build_expected(input int t);
        int angle;
        int m;
        int s;
        int last;
        real rad;
        taps_t taps;
        pe_out_s e;
        expected.delete();
        for (int n = 0; n < tests[t].count; n++)
        begin
            angle = tests[t].angles[n];
            rad = angle * 3.141592653589793 / 180.0;
            m = scaled_step($cos(rad));
            s = scaled_step($sin(rad));
            for (int i = 0; i < k_partitions; i++)
                taps[i] = line_copy[n][k_s_base + ((i * m) >> k_step_frac)];
            last = k_s_base + (((k_partitions - 1) * m) >> k_step_frac);
            for (int j = 1; j <= k_shift_steps; j++)
            begin
                taps = {line_copy[n][last + ((j * s) >> k_step_frac)], taps[k_partitions-1:1]};
                e.kick = 1'b1;
                e.scan_mode = (angle >= 45) && (angle < 135);
                e.scan_direction = (angle >= 90);
                e.taps = taps;
                expected.push_back(e);
            end
        end
    endtask

    task automatic run_test(input int t);
        logic [31:0] d;
        logic signed [k_data_width-1:0] v;
        load_lines(tests[t].count);
        for (int n = 0; n < tests[t].count; n++)
            write_word(11'h400 + 11'(n + 1), {19'd0, tests[t].angles[n], 5'd0});
        // readback of the angle table and sign extended samples
        for (int n = 0; n < tests[t].count; n++)
        begin
            read_word(11'h400 + 11'(n + 1), d);
            check("angle table", d, {19'd0, tests[t].angles[n], 5'd0});
            v = line_copy[n][k_s_base + n];
            read_word({1'b0, 3'(n), 7'(k_s_base + n)}, d);
            check("line sample", d, {{(32 - k_data_width){v[k_data_width-1]}}, v});
        end
        build_expected(t);
        kicks.delete();
        write_word(11'h400, {27'd0, tests[t].count, 1'b1});
        read_word(11'h409, d);
        check("status while running", d, 32'h1);
        do
            read_word(11'h409, d);
        while (!d[1]);
        check("status after run", d, 32'h2);
        read_word(11'h400, d);
        check("control count", d, {27'd0, tests[t].count, 1'b0});
        check("kick count", kicks.size(), tests[t].kicks);
        for (int k = 0; k < kicks.size(); k++)
        begin
            check($sformatf("pe.taps[%0d]", k), kicks[k].taps, expected[k].taps);
            check($sformatf("pe.scan_mode[%0d]", k), kicks[k].scan_mode,
                  expected[k].scan_mode);
            check($sformatf("pe.scan_direction[%0d]", k), kicks[k].scan_direction,
                  expected[k].scan_direction);
        end
    endtask

    initial
    begin
        reset_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_i = '0;
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;
        for (int t = 0; t < $size(tests); t++)
            run_test(t);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: project.f
rtl/bp_pkg.sv
rtl/bp_angle_lut.sv
rtl/bp_swappable.sv
rtl/bp_swap_control.sv
rtl/bp_filtered_ram.sv
rtl/bp_processing_top.sv
verification/bp_processing_tb.sv
